// File: src/isa_pkg.sv
package isa_pkg;

	localparam int XLEN = 32;
	localparam int REG_INDEX_WIDTH = 5;

	// ******************************
	// Instruction class and operations
	// ******************************

	typedef enum logic [2:0] {
		CLASS_ALU,
		CLASS_JUMP,
		CLASS_BRANCH,
		CLASS_LOAD,
		CLASS_STORE,
		CLASS_MULDIV
	} op_class_e;

	// Ten result operations then six compares
	typedef enum logic [3:0] {
		ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
		EQ, NE, LT, GE, LTU, GEU
	} alu_op_e;

	typedef enum logic [2:0] {
		SEL_ZERO,
		SEL_RS1,
		SEL_RS2,
		SEL_PC,
		SEL_IMM
	} operand_sel_e;

	typedef enum logic [2:0] {
		MUL, MULH, MULHSU, MULHU,
		DIV, DIVU, REM, REMU
	} muldiv_op_e;

	typedef enum logic [1:0] {
		WIDTH_BYTE,
		WIDTH_HALF,
		WIDTH_WORD
	} mem_width_e;

endpackage

// File: src/exec_pkg.sv
package exec_pkg;

	localparam int DEFAULT_TAG_WIDTH = 4;

	// Four-phase req/ack progress
	typedef enum logic [1:0] {
		HS_IDLE,
		HS_ACK,        // Own line high, waiting on the partner
		HS_WAIT_LOW    // Waiting for the partner's line to fall
	} hs_state_e;

	typedef enum logic [1:0] {
		CORE_IDLE,
		CORE_MUL,
		CORE_DIV,
		CORE_HOLD      // Result formed, result handshake in progress
	} core_state_e;

endpackage

// File: src/exec_bus_if.sv
`timescale 1ns/1ns

// Decoded instruction from receiver to core
interface issue_if #(
	parameter int TAG_WIDTH = exec_pkg::DEFAULT_TAG_WIDTH
);
	import isa_pkg::*;

	logic req;
	logic ack;
	logic [TAG_WIDTH-1:0] tag;
	logic [XLEN-1:0] pc, rs1, rs2, imm;
	logic [REG_INDEX_WIDTH-1:0] rd;
	op_class_e op_class;
	alu_op_e alu_op;
	operand_sel_e sel1, sel2;
	muldiv_op_e muldiv_op;
	mem_width_e mem_width;
	logic mem_signed;

	modport source (
		output req, tag, pc, rs1, rs2, imm, rd, op_class, alu_op, sel1, sel2,
		output muldiv_op, mem_width, mem_signed,
		input ack
	);
	modport sink (
		input req, tag, pc, rs1, rs2, imm, rd, op_class, alu_op, sel1, sel2,
		input muldiv_op, mem_width, mem_signed,
		output ack
	);
endinterface

// Finished result from core to sender
interface result_if #(
	parameter int TAG_WIDTH = exec_pkg::DEFAULT_TAG_WIDTH
);
	import isa_pkg::*;

	logic req;
	logic ack;
	logic [TAG_WIDTH-1:0] tag;
	logic [REG_INDEX_WIDTH-1:0] rd;
	logic [XLEN-1:0] rd_value, pc_next, mem_address;
	logic rd_write;
	logic mem_read, mem_write;
	mem_width_e mem_width;
	logic mem_signed;

	modport source (
		output req, tag, rd, rd_value, rd_write, pc_next,
		output mem_read, mem_write, mem_address, mem_width, mem_signed,
		input ack
	);
	modport sink (
		input req, tag, rd, rd_value, rd_write, pc_next,
		input mem_read, mem_write, mem_address, mem_width, mem_signed,
		output ack
	);
endinterface

// File: src/issue_receiver.sv
`timescale 1ns/1ns

module issue_receiver #(
	parameter int TAG_WIDTH = exec_pkg::DEFAULT_TAG_WIDTH
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_issue_req,
	output logic o_issue_ack,
	input logic [TAG_WIDTH-1:0] i_tag,
	input logic [isa_pkg::XLEN-1:0] i_pc,
	input logic [isa_pkg::XLEN-1:0] i_rs1,
	input logic [isa_pkg::XLEN-1:0] i_rs2,
	input logic [isa_pkg::XLEN-1:0] i_imm,
	input logic [isa_pkg::REG_INDEX_WIDTH-1:0] i_rd,
	input isa_pkg::op_class_e i_op_class,
	input isa_pkg::alu_op_e i_alu_op,
	input isa_pkg::operand_sel_e i_sel1,
	input isa_pkg::operand_sel_e i_sel2,
	input isa_pkg::muldiv_op_e i_muldiv_op,
	input isa_pkg::mem_width_e i_mem_width,
	input logic i_mem_signed,
	issue_if.source src
);
	import exec_pkg::*;

	hs_state_e host_state;
	hs_state_e link_state;   // HS_IDLE here means the buffer is free
	logic capture;

	assign capture = (host_state == HS_IDLE) && i_issue_req && (link_state == HS_IDLE);
	assign o_issue_ack = (host_state == HS_ACK);
	assign src.req = (link_state == HS_ACK);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			host_state <= HS_IDLE;
			link_state <= HS_IDLE;
		end else begin
			case (host_state)
				HS_IDLE: if (capture) host_state <= HS_ACK;
				default: if (!i_issue_req) host_state <= HS_IDLE;
			endcase

			// Buffer is held until the core's ack has fallen
			case (link_state)
				HS_IDLE: if (capture) link_state <= HS_ACK;
				HS_ACK: if (src.ack) link_state <= HS_WAIT_LOW;
				default: if (!src.ack) link_state <= HS_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (capture) begin
			src.tag <= i_tag;
			src.pc <= i_pc;
			src.rs1 <= i_rs1;
			src.rs2 <= i_rs2;
			src.imm <= i_imm;
			src.rd <= i_rd;
			src.op_class <= i_op_class;
			src.alu_op <= i_alu_op;
			src.sel1 <= i_sel1;
			src.sel2 <= i_sel2;
			src.muldiv_op <= i_muldiv_op;
			src.mem_width <= i_mem_width;
			src.mem_signed <= i_mem_signed;
		end
	end

endmodule

// File: src/alu.sv
`timescale 1ns/1ns

module alu (
	input isa_pkg::alu_op_e i_op,
	input logic [isa_pkg::XLEN-1:0] i_a,
	input logic [isa_pkg::XLEN-1:0] i_b,
	output logic [isa_pkg::XLEN-1:0] o_result,
	output logic o_compare
);
	import isa_pkg::*;

	localparam int SHAMT_WIDTH = $clog2(XLEN);

	logic [SHAMT_WIDTH-1:0] shamt;
	logic equal;
	logic signed_lt;
	logic unsigned_lt;

	assign shamt = i_b[SHAMT_WIDTH-1:0];
	assign equal = (i_a == i_b);
	assign signed_lt = ($signed(i_a) < $signed(i_b));
	assign unsigned_lt = (i_a < i_b);

	always_comb begin
		case (i_op)
			ADD: o_result = i_a + i_b;
			SUB: o_result = i_a - i_b;
			SLL: o_result = i_a << shamt;
			SLT: o_result = XLEN'(signed_lt);
			SLTU: o_result = XLEN'(unsigned_lt);
			XOR: o_result = i_a ^ i_b;
			SRL: o_result = i_a >> shamt;
			SRA: o_result = $signed(i_a) >>> shamt;   // Arithmetic, keeps the sign
			OR: o_result = i_a | i_b;
			AND: o_result = i_a & i_b;
			default: o_result = '0;   // Compares give no result
		endcase
	end

	// Branch condition, separate from the result mux
	always_comb begin
		case (i_op)
			EQ: o_compare = equal;
			NE: o_compare = !equal;
			LT: o_compare = signed_lt;
			GE: o_compare = !signed_lt;
			LTU: o_compare = unsigned_lt;
			GEU: o_compare = !unsigned_lt;
			default: o_compare = 1'b0;
		endcase
	end

endmodule

// File: src/divider.sv
`timescale 1ns/1ns

module divider (
	input logic i_clock,
	input logic i_reset,
	input logic i_start,
	input logic i_signed,
	input logic [isa_pkg::XLEN-1:0] i_numerator,
	input logic [isa_pkg::XLEN-1:0] i_denominator,
	output logic [isa_pkg::XLEN-1:0] o_quotient,
	output logic [isa_pkg::XLEN-1:0] o_remainder,
	output logic o_done
);
	import isa_pkg::*;

	localparam int COUNT_WIDTH = $clog2(XLEN);

	logic busy;
	logic [COUNT_WIDTH-1:0] count;
	logic [XLEN-1:0] partial;     // Partial remainder
	logic [XLEN-1:0] quotient;    // Dividend shifts out as quotient bits shift in
	logic [XLEN-1:0] divisor;
	logic [XLEN-1:0] numerator;
	logic negate_q;
	logic negate_r;
	logic by_zero;
	logic [XLEN:0] shifted;
	logic [XLEN:0] trial;

	assign shifted = {partial, quotient[XLEN-1]};
	assign trial = shifted - {1'b0, divisor};   // Top bit set means restore

	// The most negative value over -1 wraps back to itself, as RISC-V wants
	assign o_quotient = by_zero ? '1 : (negate_q ? -quotient : quotient);
	assign o_remainder = by_zero ? numerator : (negate_r ? -partial : partial);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy <= 1'b0;
			count <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (i_start) begin
				busy <= 1'b1;
				count <= '0;
				partial <= '0;
				quotient <= (i_signed && i_numerator[XLEN-1]) ? -i_numerator : i_numerator;
				divisor <= (i_signed && i_denominator[XLEN-1]) ? -i_denominator : i_denominator;
				numerator <= i_numerator;
				negate_q <= i_signed && (i_numerator[XLEN-1] ^ i_denominator[XLEN-1]);
				negate_r <= i_signed && i_numerator[XLEN-1];
				by_zero <= (i_denominator == '0);
			end else if (busy) begin
				partial <= trial[XLEN] ? shifted[XLEN-1:0] : trial[XLEN-1:0];
				quotient <= {quotient[XLEN-2:0], !trial[XLEN]};
				count <= count + 1'b1;
				if (count == COUNT_WIDTH'(XLEN - 1)) begin
					busy <= 1'b0;
					o_done <= 1'b1;
				end
			end
		end
	end

endmodule

// File: src/execute_core.sv
`timescale 1ns/1ns

module execute_core #(
	parameter int TAG_WIDTH = exec_pkg::DEFAULT_TAG_WIDTH
) (
	input logic i_clock,
	input logic i_reset,
	issue_if.sink iss,
	result_if.source res
);
	import isa_pkg::*;
	import exec_pkg::*;

	core_state_e state;
	logic res_sent;                 // Sender has acked, waiting for its ack to fall
	logic [TAG_WIDTH-1:0] tag_q;
	muldiv_op_e md_op;
	logic [XLEN-1:0] mul_a;
	logic [XLEN-1:0] mul_b;
	logic mul_a_signed;
	logic mul_b_signed;
	logic signed [2*XLEN+1:0] product;
	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] alu_result;
	logic alu_compare;
	logic [XLEN-1:0] pc_plus4;
	logic take;
	logic is_div;
	logic div_start;
	logic div_signed;
	logic [XLEN-1:0] div_quotient;
	logic [XLEN-1:0] div_remainder;
	logic div_done;

	function automatic logic [XLEN-1:0] pick_operand(
		input operand_sel_e sel,
		input logic [XLEN-1:0] rs1,
		input logic [XLEN-1:0] rs2,
		input logic [XLEN-1:0] pc,
		input logic [XLEN-1:0] imm
	);
		case (sel)
			SEL_RS1: return rs1;
			SEL_RS2: return rs2;
			SEL_PC: return pc;
			SEL_IMM: return imm;
			default: return '0;
		endcase
	endfunction

	assign op_a = pick_operand(iss.sel1, iss.rs1, iss.rs2, iss.pc, iss.imm);
	assign op_b = pick_operand(iss.sel2, iss.rs1, iss.rs2, iss.pc, iss.imm);
	assign pc_plus4 = iss.pc + XLEN'(4);
	assign take = (state == CORE_IDLE) && iss.req && !iss.ack;
	assign is_div = iss.muldiv_op inside {DIV, DIVU, REM, REMU};
	assign div_start = take && (iss.op_class == CLASS_MULDIV) && is_div;
	assign div_signed = iss.muldiv_op inside {DIV, REM};
	assign res.tag = tag_q;

	alu u_alu (
		.i_op(iss.alu_op),
		.i_a(op_a),
		.i_b(op_b),
		.o_result(alu_result),
		.o_compare(alu_compare)
	);

	divider u_divider (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_start(div_start),
		.i_signed(div_signed),
		.i_numerator(op_a),
		.i_denominator(op_b),
		.o_quotient(div_quotient),
		.o_remainder(div_remainder),
		.o_done(div_done)
	);

	// ******************************
	// Multiply on registered operands
	// ******************************
	assign mul_a_signed = (md_op != MULHU);
	assign mul_b_signed = (md_op == MUL) || (md_op == MULH);
	assign product = $signed({mul_a_signed & mul_a[XLEN-1], mul_a})
		* $signed({mul_b_signed & mul_b[XLEN-1], mul_b});

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= CORE_IDLE;
			iss.ack <= 1'b0;
			res.req <= 1'b0;
			res_sent <= 1'b0;
		end else begin
			if (iss.ack && !iss.req)
				iss.ack <= 1'b0;

			case (state)
				CORE_IDLE: if (take) begin
					iss.ack <= 1'b1;
					tag_q <= iss.tag;
					res.rd <= iss.rd;
					res.rd_value <= alu_result;
					res.rd_write <= iss.op_class inside {CLASS_ALU, CLASS_JUMP, CLASS_LOAD, CLASS_MULDIV};
					res.pc_next <= pc_plus4;
					res.mem_read <= (iss.op_class == CLASS_LOAD);
					res.mem_write <= (iss.op_class == CLASS_STORE);
					res.mem_address <= alu_result;
					res.mem_width <= iss.mem_width;
					res.mem_signed <= iss.mem_signed;
					mul_a <= op_a;
					mul_b <= op_b;
					md_op <= iss.muldiv_op;
					state <= CORE_HOLD;
					case (iss.op_class)
						CLASS_JUMP: begin
							res.rd_value <= pc_plus4;   // Link value
							res.pc_next <= alu_result;
						end
						CLASS_BRANCH: if (alu_compare) res.pc_next <= iss.pc + iss.imm;
						CLASS_STORE: res.rd_value <= iss.rs2;
						CLASS_MULDIV: state <= is_div ? CORE_DIV : CORE_MUL;
						default: ;
					endcase
				end
				CORE_MUL: begin
					res.rd_value <= (md_op == MUL) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];
					state <= CORE_HOLD;
				end
				CORE_DIV: if (div_done) begin
					res.rd_value <= (md_op inside {DIV, DIVU}) ? div_quotient : div_remainder;
					state <= CORE_HOLD;
				end
				default: begin
					// Result handshake, back to idle once the sender's ack is low
					if (!res_sent) begin
						if (!res.req) begin
							res.req <= 1'b1;
						end else if (res.ack) begin
							res.req <= 1'b0;
							res_sent <= 1'b1;
						end
					end else if (!res.ack) begin
						res_sent <= 1'b0;
						state <= CORE_IDLE;
					end
				end
			endcase
		end
	end

endmodule

// File: src/result_sender.sv
`timescale 1ns/1ns

module result_sender #(
	parameter int TAG_WIDTH = exec_pkg::DEFAULT_TAG_WIDTH
) (
	input logic i_clock,
	input logic i_reset,
	result_if.sink res,
	output logic o_res_req,
	input logic i_res_ack,
	output logic [TAG_WIDTH-1:0] o_tag,
	output logic [isa_pkg::REG_INDEX_WIDTH-1:0] o_rd,
	output logic [isa_pkg::XLEN-1:0] o_rd_value,
	output logic o_rd_write,
	output logic [isa_pkg::XLEN-1:0] o_pc_next,
	output logic o_mem_read,
	output logic o_mem_write,
	output logic [isa_pkg::XLEN-1:0] o_mem_address,
	output isa_pkg::mem_width_e o_mem_width,
	output logic o_mem_signed
);
	import exec_pkg::*;

	hs_state_e host_state;
	logic full;
	logic capture;

	assign capture = res.req && !res.ack && !full;
	assign o_res_req = (host_state == HS_ACK);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			host_state <= HS_IDLE;
			full <= 1'b0;
			res.ack <= 1'b0;
		end else begin
			if (capture) begin
				res.ack <= 1'b1;
				full <= 1'b1;
			end else if (res.ack && !res.req) begin
				res.ack <= 1'b0;
			end

			case (host_state)
				HS_IDLE: if (full) host_state <= HS_ACK;
				HS_ACK: if (i_res_ack) host_state <= HS_WAIT_LOW;
				default: if (!i_res_ack) begin
					host_state <= HS_IDLE;
					full <= 1'b0;   // Host is done with it
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (capture) begin
			o_tag <= res.tag;
			o_rd <= res.rd;
			o_rd_value <= res.rd_value;
			o_rd_write <= res.rd_write;
			o_pc_next <= res.pc_next;
			o_mem_read <= res.mem_read;
			o_mem_write <= res.mem_write;
			o_mem_address <= res.mem_address;
			o_mem_width <= res.mem_width;
			o_mem_signed <= res.mem_signed;
		end
	end

endmodule

// File: src/execute_unit.sv
`timescale 1ns/1ns

module execute_unit #(
	parameter int TAG_WIDTH = exec_pkg::DEFAULT_TAG_WIDTH
) (
	input logic i_clock,
	input logic i_reset,

	// Issue port
	input logic i_issue_req,
	output logic o_issue_ack,
	input logic [TAG_WIDTH-1:0] i_tag,
	input logic [isa_pkg::XLEN-1:0] i_pc,
	input logic [isa_pkg::XLEN-1:0] i_rs1,
	input logic [isa_pkg::XLEN-1:0] i_rs2,
	input logic [isa_pkg::XLEN-1:0] i_imm,
	input logic [isa_pkg::REG_INDEX_WIDTH-1:0] i_rd,
	input isa_pkg::op_class_e i_op_class,
	input isa_pkg::alu_op_e i_alu_op,
	input isa_pkg::operand_sel_e i_sel1,
	input isa_pkg::operand_sel_e i_sel2,
	input isa_pkg::muldiv_op_e i_muldiv_op,
	input isa_pkg::mem_width_e i_mem_width,
	input logic i_mem_signed,

	// Result port
	output logic o_res_req,
	input logic i_res_ack,
	output logic [TAG_WIDTH-1:0] o_tag,
	output logic [isa_pkg::REG_INDEX_WIDTH-1:0] o_rd,
	output logic [isa_pkg::XLEN-1:0] o_rd_value,
	output logic o_rd_write,
	output logic [isa_pkg::XLEN-1:0] o_pc_next,
	output logic o_mem_read,
	output logic o_mem_write,
	output logic [isa_pkg::XLEN-1:0] o_mem_address,
	output isa_pkg::mem_width_e o_mem_width,
	output logic o_mem_signed
);

	issue_if #(.TAG_WIDTH(TAG_WIDTH)) issue_bus ();
	result_if #(.TAG_WIDTH(TAG_WIDTH)) result_bus ();

	issue_receiver #(.TAG_WIDTH(TAG_WIDTH)) u_issue_receiver (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_issue_req(i_issue_req),
		.o_issue_ack(o_issue_ack),
		.i_tag(i_tag),
		.i_pc(i_pc),
		.i_rs1(i_rs1),
		.i_rs2(i_rs2),
		.i_imm(i_imm),
		.i_rd(i_rd),
		.i_op_class(i_op_class),
		.i_alu_op(i_alu_op),
		.i_sel1(i_sel1),
		.i_sel2(i_sel2),
		.i_muldiv_op(i_muldiv_op),
		.i_mem_width(i_mem_width),
		.i_mem_signed(i_mem_signed),
		.src(issue_bus.source)
	);

	execute_core #(.TAG_WIDTH(TAG_WIDTH)) u_execute_core (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.iss(issue_bus.sink),
		.res(result_bus.source)
	);

	result_sender #(.TAG_WIDTH(TAG_WIDTH)) u_result_sender (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.res(result_bus.sink),
		.o_res_req(o_res_req),
		.i_res_ack(i_res_ack),
		.o_tag(o_tag),
		.o_rd(o_rd),
		.o_rd_value(o_rd_value),
		.o_rd_write(o_rd_write),
		.o_pc_next(o_pc_next),
		.o_mem_read(o_mem_read),
		.o_mem_write(o_mem_write),
		.o_mem_address(o_mem_address),
		.o_mem_width(o_mem_width),
		.o_mem_signed(o_mem_signed)
	);

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
	parameter int HALF_PERIOD = 10,
	parameter int RESET_CYCLES = 4
) (
	output logic o_clock,
	output logic o_reset
);

	initial begin
		o_clock = 1'b0;
		forever #HALF_PERIOD o_clock = ~o_clock;
	end

	initial begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clock);
		#2 o_reset = 1'b0;   // Released just after the last reset edge
	end

endmodule

// File: tests/tb_execute_unit.sv
`timescale 1ns/1ns

module tb_execute_unit;
	import isa_pkg::*;

	localparam int TAG_WIDTH = 4;
	localparam int NUM_INSTR = 400;
	localparam int MAX_CYCLES = NUM_INSTR * 60;   // Worst case per instruction
	localparam int DRIVE_DELAY = 2;

	typedef struct packed {
		logic [TAG_WIDTH-1:0] tag;
		logic [REG_INDEX_WIDTH-1:0] rd;
		logic [XLEN-1:0] rd_value;
		logic check_value;
		logic rd_write;
		logic [XLEN-1:0] pc_next;
		logic check_mem;
		logic mem_read;
		logic mem_write;
		logic [XLEN-1:0] mem_address;
		logic [1:0] mem_width;
		logic mem_signed;
		logic [2:0] ack_delay;     // Host ack delay for this result
	} expect_t;

	logic i_clock, i_reset;
	logic i_issue_req, o_issue_ack;
	logic [TAG_WIDTH-1:0] i_tag;
	logic [XLEN-1:0] i_pc, i_rs1, i_rs2, i_imm;
	logic [REG_INDEX_WIDTH-1:0] i_rd;
	op_class_e i_op_class;
	alu_op_e i_alu_op;
	operand_sel_e i_sel1, i_sel2;
	muldiv_op_e i_muldiv_op;
	mem_width_e i_mem_width;
	logic i_mem_signed;
	logic o_res_req, i_res_ack;
	logic [TAG_WIDTH-1:0] o_tag;
	logic [REG_INDEX_WIDTH-1:0] o_rd;
	logic [XLEN-1:0] o_rd_value, o_pc_next, o_mem_address;
	logic o_rd_write, o_mem_read, o_mem_write, o_mem_signed;
	mem_width_e o_mem_width;

	integer seed = 50109;
	int received = 0;
	int cycle_count = 0;
	expect_t expected_q[$];

	tb_clock_gen u_clock_gen (.o_clock(i_clock), .o_reset(i_reset));

	execute_unit #(.TAG_WIDTH(TAG_WIDTH)) u_execute_unit (.*);

	// ******************************
	// Reference model
	// ******************************
	function automatic logic [XLEN-1:0] select_operand(input operand_sel_e sel,
		input logic [XLEN-1:0] rs1, input logic [XLEN-1:0] rs2,
		input logic [XLEN-1:0] pc, input logic [XLEN-1:0] imm);
		case (sel)
			SEL_RS1: return rs1;
			SEL_RS2: return rs2;
			SEL_PC: return pc;
			SEL_IMM: return imm;
			default: return '0;
		endcase
	endfunction

	function automatic logic [XLEN-1:0] alu_model(input alu_op_e op,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		case (op)
			ADD: return a + b;
			SUB: return a - b;
			SLL: return a << b[4:0];
			SLT: return ($signed(a) < $signed(b)) ? 1 : 0;
			SLTU: return (a < b) ? 1 : 0;
			XOR: return a ^ b;
			SRL: return a >> b[4:0];
			SRA: return $signed(a) >>> b[4:0];
			OR: return a | b;
			AND: return a & b;
			default: return '0;
		endcase
	endfunction

	function automatic logic compare_model(input alu_op_e op,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		case (op)
			EQ: return a == b;
			NE: return a != b;
			LT: return $signed(a) < $signed(b);
			GE: return $signed(a) >= $signed(b);
			LTU: return a < b;
			GEU: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [XLEN-1:0] muldiv_model(input muldiv_op_e op,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic [2*XLEN-1:0] product;
		logic signed [XLEN-1:0] sa;
		logic signed [XLEN-1:0] sb;
		logic signed [XLEN-1:0] sq;
		logic signed [XLEN-1:0] sr;
		logic overflow;
		sa = a;
		sb = b;
		sq = '0;
		sr = '0;
		overflow = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);
		// Signed quotient and remainder in signed variables, rounding toward zero
		if (b != '0 && !overflow) begin
			sq = sa / sb;
			sr = sa % sb;
		end
		case (op)
			MUL: product = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
			MULH: product = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{b[XLEN-1]}}, b};
			MULHSU: product = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{1'b0}}, b};
			default: product = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
		endcase
		case (op)
			MUL: return product[XLEN-1:0];
			MULH, MULHSU, MULHU: return product[2*XLEN-1:XLEN];
			DIV: return (b == '0) ? '1 : (overflow ? a : sq);
			DIVU: return (b == '0) ? '1 : a / b;
			REM: return (b == '0) ? a : (overflow ? '0 : sr);
			default: return (b == '0) ? a : a % b;
		endcase
	endfunction

	// ******************************
	// Helpers
	// ******************************
	task automatic next_cycle();
		@(posedge i_clock);
		#DRIVE_DELAY;
	endtask

	task automatic end_in_failure();
		$display("FAIL: see errors above");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [XLEN-1:0] expected,
		input logic [XLEN-1:0] actual);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			end_in_failure();
		end
	endtask

	// Draws one instruction onto the issue inputs and returns what should come back
	task automatic make_instruction(input int index, output expect_t exp);
		op_class_e cls;
		int corner;
		logic [XLEN-1:0] op_a;
		logic [XLEN-1:0] op_b;
		cls = op_class_e'($unsigned($random(seed)) % 6);
		corner = $unsigned($random(seed)) % 6;
		i_tag = TAG_WIDTH'(index);
		i_pc = $random(seed);
		i_rs1 = $random(seed);
		i_rs2 = $random(seed);
		i_imm = $random(seed);
		i_rd = REG_INDEX_WIDTH'($random(seed));
		i_op_class = cls;
		i_alu_op = alu_op_e'($unsigned($random(seed)) % 10);
		i_sel1 = operand_sel_e'($unsigned($random(seed)) % 5);
		i_sel2 = operand_sel_e'($unsigned($random(seed)) % 5);
		i_muldiv_op = muldiv_op_e'($unsigned($random(seed)) % 8);
		i_mem_width = mem_width_e'($unsigned($random(seed)) % 3);
		i_mem_signed = $random(seed) & 1;
		// First sixteen cover every multiply and divide op at both corners
		if (index < 16) begin
			cls = CLASS_MULDIV;
			i_op_class = cls;
			i_muldiv_op = muldiv_op_e'(index % 8);
			corner = index / 8;
		end
		case (corner)
			0: i_rs2 = '0;                                            // Divide by zero
			1: begin
				i_rs1 = {1'b1, {(XLEN-1){1'b0}}};                     // Overflow case
				i_rs2 = '1;
			end
			2: i_rs2 = i_rs1;
			3: i_rs2 = $unsigned($random(seed)) % 40;
			default: ;
		endcase
		case (cls)
			CLASS_JUMP: begin
				i_alu_op = ADD;
				i_sel1 = ($random(seed) & 1) ? SEL_PC : SEL_RS1;
				i_sel2 = SEL_IMM;
			end
			CLASS_BRANCH: begin
				i_alu_op = alu_op_e'(10 + $unsigned($random(seed)) % 6);
				i_sel1 = SEL_RS1;
				i_sel2 = SEL_RS2;
			end
			CLASS_LOAD, CLASS_STORE: begin
				i_alu_op = ADD;
				i_sel1 = SEL_RS1;
				i_sel2 = SEL_IMM;
			end
			CLASS_MULDIV: begin
				i_sel1 = SEL_RS1;
				i_sel2 = SEL_RS2;
			end
			default: ;
		endcase

		op_a = select_operand(i_sel1, i_rs1, i_rs2, i_pc, i_imm);
		op_b = select_operand(i_sel2, i_rs1, i_rs2, i_pc, i_imm);
		exp = '0;
		exp.tag = i_tag;
		exp.rd = i_rd;
		exp.ack_delay = $unsigned($random(seed)) % 6;
		exp.rd_write = cls inside {CLASS_ALU, CLASS_JUMP, CLASS_LOAD, CLASS_MULDIV};
		exp.check_value = cls inside {CLASS_ALU, CLASS_JUMP, CLASS_STORE, CLASS_MULDIV};
		exp.check_mem = cls inside {CLASS_LOAD, CLASS_STORE};
		exp.pc_next = i_pc + 4;
		exp.mem_read = (cls == CLASS_LOAD);
		exp.mem_write = (cls == CLASS_STORE);
		exp.mem_address = alu_model(i_alu_op, op_a, op_b);
		exp.mem_width = i_mem_width;
		exp.mem_signed = i_mem_signed;
		case (cls)
			CLASS_ALU: exp.rd_value = alu_model(i_alu_op, op_a, op_b);
			CLASS_JUMP: begin
				exp.rd_value = i_pc + 4;
				exp.pc_next = alu_model(i_alu_op, op_a, op_b);
			end
			CLASS_BRANCH: if (compare_model(i_alu_op, op_a, op_b)) exp.pc_next = i_pc + i_imm;
			CLASS_STORE: exp.rd_value = i_rs2;
			CLASS_MULDIV: exp.rd_value = muldiv_model(i_muldiv_op, op_a, op_b);
			default: ;
		endcase
	endtask

	// ******************************
	// Driver
	// ******************************
	initial begin : drive_instructions
		expect_t exp;
		int gap;
		i_issue_req = 1'b0;
		i_tag = '0;
		i_pc = '0;
		i_rs1 = '0;
		i_rs2 = '0;
		i_imm = '0;
		i_rd = '0;
		i_op_class = CLASS_ALU;
		i_alu_op = ADD;
		i_sel1 = SEL_ZERO;
		i_sel2 = SEL_ZERO;
		i_muldiv_op = MUL;
		i_mem_width = WIDTH_WORD;
		i_mem_signed = 1'b0;
		@(negedge i_reset);
		check_value("o_issue_ack", 0, o_issue_ack);
		check_value("o_res_req", 0, o_res_req);

		for (int n = 0; n < NUM_INSTR; n++) begin
			gap = $unsigned($random(seed)) % 3;
			repeat (gap) next_cycle();
			make_instruction(n, exp);
			expected_q.push_back(exp);
			i_issue_req = 1'b1;
			do next_cycle(); while (!o_issue_ack);
			i_issue_req = 1'b0;
			do next_cycle(); while (o_issue_ack);
		end

		wait (received == NUM_INSTR);
		repeat (20) next_cycle();   // Quiet window where a stray result would show up
		$display("PASS: all tests");
		$finish;
	end

	// ******************************
	// Monitor
	// ******************************
	initial begin : check_results
		expect_t exp;
		i_res_ack = 1'b0;
		@(negedge i_reset);
		forever begin
			next_cycle();
			if (o_res_req) begin
				if (expected_q.size() == 0) begin
					$display("Error at %0t ns: a result came out with no instruction pending",
						$time);
					end_in_failure();
				end
				exp = expected_q.pop_front();
				repeat (exp.ack_delay) next_cycle();
				check_value("o_tag", exp.tag, o_tag);
				check_value("o_rd", exp.rd, o_rd);
				check_value("o_rd_write", exp.rd_write, o_rd_write);
				check_value("o_pc_next", exp.pc_next, o_pc_next);
				check_value("o_mem_read", exp.mem_read, o_mem_read);
				check_value("o_mem_write", exp.mem_write, o_mem_write);
				if (exp.check_value)
					check_value("o_rd_value", exp.rd_value, o_rd_value);
				if (exp.check_mem) begin
					check_value("o_mem_address", exp.mem_address, o_mem_address);
					check_value("o_mem_width", exp.mem_width, o_mem_width);
					check_value("o_mem_signed", exp.mem_signed, o_mem_signed);
				end
				i_res_ack = 1'b1;
				do next_cycle(); while (o_res_req);
				i_res_ack = 1'b0;
				received++;
			end
		end
	end

	initial begin : watchdog
		while (cycle_count < MAX_CYCLES) begin
			@(posedge i_clock);
			cycle_count++;
		end
		$display("Error: run timed out after %0d cycles with %0d of %0d results received",
			cycle_count, received, NUM_INSTR);
		end_in_failure();
	end

endmodule

// File: project.f
src/isa_pkg.sv
src/exec_pkg.sv
src/exec_bus_if.sv
src/issue_receiver.sv
src/alu.sv
src/divider.sv
src/execute_core.sv
src/result_sender.sv
src/execute_unit.sv
tests/tb_clock_gen.sv
tests/tb_execute_unit.sv

// File: Bender.yml
package:
  name: execute_unit

sources:
  - src/isa_pkg.sv
  - src/exec_pkg.sv
  - src/exec_bus_if.sv
  - src/issue_receiver.sv
  - src/alu.sv
  - src/divider.sv
  - src/execute_core.sv
  - src/result_sender.sv
  - src/execute_unit.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_execute_unit.sv
